// File: build.f
cplx_fmt_pkg.sv
cplx_status_pkg.sv
fixed_round_sat.sv
lane_pipe_reg.sv
lane_mul_stage.sv
lane_fma_stage.sv
complex_mul.sv
tb_complex_mul.sv

// File: Bender.yml
package:
  name: complex_mul

sources:
  - cplx_fmt_pkg.sv
  - cplx_status_pkg.sv
  - fixed_round_sat.sv
  - lane_pipe_reg.sv
  - lane_mul_stage.sv
  - lane_fma_stage.sv
  - complex_mul.sv
  - target: test
    files:
      - tb_complex_mul.sv

// File: tb_complex_mul.sv
module tb_complex_mul;

  timeunit 1ns;
  timeprecision 1ps;

  import cplx_fmt_pkg::*;
  import cplx_status_pkg::*;

  localparam int RESET_CYCLES  = 8;
  localparam int N_DIRECTED    = 12;
  localparam int N_RANDOM      = 520;
  localparam int N_FLUSHED     = 2;
  localparam int N_AFTER_FLUSH = 60;
  localparam int TOTAL_OPS     = N_DIRECTED + N_RANDOM + N_FLUSHED + N_AFTER_FLUSH;
  localparam int DRAIN_CYCLES  = 100;
  localparam int CYCLE_LIMIT   = 4 * TOTAL_OPS + RESET_CYCLES + DRAIN_CYCLES;

  // out_ready_i modes
  localparam int READY_ALWAYS = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_HOLD   = 2;

  logic                clk_i;
  logic                reset_i;
  logic [4*COMP_W-1:0] operands_i;
  logic                in_valid_i;
  logic                in_ready_o;
  logic                flush_i;
  cplx_word_u          result_o;
  logic [STATUS_W-1:0] status_o;
  logic                out_valid_o;
  logic                out_ready_i;
  logic                busy_o;

  logic [31:0]          lfsr_q;
  int                   ready_mode;
  int                   cycle_cnt = 0;
  int                   n_pushed = 0;
  int                   n_checked = 0;
  int                   n_flushed = 0;
  string                test_name;
  // {status, im, re} per accepted operation
  logic [STATUS_W+31:0] exp_q[$];
  logic [STATUS_W+31:0] model_word;
  logic [63:0]          directed_ops [N_DIRECTED];

  complex_mul complex_mul_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .operands_i  (operands_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  always #10 clk_i = ~clk_i;

  // galois form, taps for x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'hd000_0001;
    end
    return state >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits   = {bits[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return bits;
  endfunction

  // returns {nx, ov, comp}; wide carries FRAC_W extra fraction bits
  function automatic logic [17:0] round_sat(input longint wide);
    longint q;
    longint rem;
    logic   ov;
    logic   nx;
    q   = wide >>> FRAC_W;
    rem = wide - (q <<< FRAC_W);
    nx  = (rem != 0);
    // above half, or exactly half with an odd quotient
    if (rem > (1 << (FRAC_W - 1)) || (rem == (1 << (FRAC_W - 1)) && q[0])) begin
      q = q + 1;
    end
    ov = 1'b0;
    if (q > COMP_MAX) begin
      q  = COMP_MAX;
      ov = 1'b1;
    end else if (q < COMP_MIN) begin
      q  = COMP_MIN;
      ov = 1'b1;
    end
    return {nx, ov, q[15:0]};
  endfunction

  // expected {status, im, re} for operands packed as {b2, a2, b1, a1}
  function automatic logic [STATUS_W+31:0] ref_model(input logic [63:0] ops);
    longint              a1, b1, a2, b2, nb1;
    logic [17:0]         mul_re, mul_im, out_re, out_im;
    logic [STATUS_W-1:0] st;
    logic                neg_ov;
    a1 = $signed(ops[15:0]);
    b1 = $signed(ops[31:16]);
    a2 = $signed(ops[47:32]);
    b2 = $signed(ops[63:48]);
    neg_ov = (b1 == -32768);
    nb1    = neg_ov ? 32767 : -b1;
    mul_re = round_sat(a1 * a2);
    mul_im = round_sat(a1 * b2);
    out_re = round_sat(nb1 * b2 + ($signed(mul_re[15:0]) <<< FRAC_W));
    out_im = round_sat(b1 * a2 + ($signed(mul_im[15:0]) <<< FRAC_W));
    st        = '0;
    st[ST_OV] = neg_ov | mul_re[16] | mul_im[16] | out_re[16] | out_im[16];
    st[ST_NX] = mul_re[17] | mul_im[17] | out_re[17] | out_im[17];
    return {st, out_im[15:0], out_re[15:0]};
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("error %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  task automatic check_reset_state(input string name);
    check_value({name, " out_valid_o"}, 64'd0, out_valid_o);
    check_value({name, " busy_o"}, 64'd0, busy_o);
    check_value({name, " in_ready_o"}, 64'd1, in_ready_o);
  endtask

  // takes effect at the next falling edge
  task automatic set_ready_mode(input int mode);
    @(posedge clk_i);
    ready_mode = mode;
  endtask

  // returns at the rising edge where the transfer happened
  task automatic send_op(input logic [63:0] ops, input logic with_gaps);
    int gap;
    gap = 0;
    if (with_gaps && take_bits(2) == 0) begin
      gap = take_bits(2);
    end
    if (gap > 0) begin
      @(negedge clk_i);
      in_valid_i = 1'b0;
      repeat (gap - 1) @(negedge clk_i);
    end
    @(negedge clk_i);
    operands_i = ops;
    in_valid_i = 1'b1;
    do @(posedge clk_i); while (!in_ready_o);
  endtask

  task automatic drop_valid();
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    do @(negedge clk_i); while (exp_q.size() != 0 || busy_o);
  endtask

  always @(negedge clk_i) begin
    case (ready_mode)
      READY_RANDOM: out_ready_i = (take_bits(2) != 0);
      READY_HOLD:   out_ready_i = 1'b0;
      default:      out_ready_i = 1'b1;
    endcase
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      stop_with_failure($sformatf("timeout after %0d cycles, the pipeline stopped moving",
                                  cycle_cnt));
    end
  end

  always @(posedge clk_i) begin : compare_outputs
    logic [STATUS_W+31:0] exp_word;
    if (!reset_i) begin
      if (flush_i) begin
        n_flushed += exp_q.size();
        exp_q.delete();
      end else begin
        if (out_valid_o && out_ready_i) begin
          if (exp_q.size() == 0) begin
            stop_with_failure("a result came out while no operation was pending");
          end else begin
            exp_word = exp_q.pop_front();
            check_value(test_name, exp_word,
                        {status_o, result_o.parts.im, result_o.parts.re});
            n_checked++;
          end
        end
        if (in_valid_i && in_ready_o) begin
          exp_q.push_back(ref_model(operands_i));
          n_pushed++;
        end
      end
    end
  end

  initial begin
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    operands_i = '0;
    out_ready_i = 1'b0;
    lfsr_q     = 32'h55c1_28b7;
    ready_mode = READY_HOLD;
    test_name  = "reset";

    // operands as {b2, a2, b1, a1}
    directed_ops[0]  = 64'hc000_4000_2000_4000;
    directed_ops[1]  = 64'h0000_4000_0000_4000;
    directed_ops[2]  = 64'h4000_4000_0000_0001;
    directed_ops[3]  = 64'h4000_4000_0000_0003;
    directed_ops[4]  = 64'hc000_4000_0003_0000;
    directed_ops[5]  = 64'h4000_4000_0000_0002;
    directed_ops[6]  = 64'h0000_8000_0000_8000;
    directed_ops[7]  = 64'h4000_4000_8000_0000;
    directed_ops[8]  = 64'h8000_8000_8000_8000;
    directed_ops[9]  = 64'h8001_7fff_7fff_7fff;
    directed_ops[10] = 64'h7fff_7fff_7fff_8000;
    directed_ops[11] = 64'h0000_0000_0000_0000;

    repeat (RESET_CYCLES) begin
      @(negedge clk_i);
      check_reset_state("reset asserted");
    end
    reset_i = 1'b0;
    @(negedge clk_i);
    check_reset_state("reset released");

    // hand-worked values for the model itself
    check_value("model exact product", 34'h0_f000_3000, ref_model(directed_ops[0]));
    check_value("model tie to even down", 34'h2_0000_0000, ref_model(directed_ops[2]));
    check_value("model tie to even up", 34'h2_0002_0002, ref_model(directed_ops[3]));
    check_value("model no dropped bits", 34'h0_0001_0001, ref_model(directed_ops[5]));
    check_value("model minus one squared", 34'h1_0000_7fff, ref_model(directed_ops[6]));
    model_word = ref_model(directed_ops[7]);
    check_value("model b1 minus one ov", 64'd1, model_word[32 + ST_OV]);
    model_word = ref_model(directed_ops[9]);
    check_value("model sat max re", 16'h7fff, model_word[15:0]);
    check_value("model sat max ov", 64'd1, model_word[32 + ST_OV]);
    model_word = ref_model(directed_ops[10]);
    check_value("model sat min re", 16'h8000, model_word[15:0]);
    check_value("model sat min ov", 64'd1, model_word[32 + ST_OV]);

    test_name = "directed";
    set_ready_mode(READY_ALWAYS);
    for (int i = 0; i < N_DIRECTED; i++) begin
      send_op(directed_ops[i], 1'b0);
    end
    drop_valid();
    wait_drain();

    test_name = "random stream";
    set_ready_mode(READY_RANDOM);
    for (int i = 0; i < N_RANDOM; i++) begin
      send_op({take_bits(32), take_bits(32)}, 1'b1);
    end
    drop_valid();
    wait_drain();

    // fill both stages behind a stalled output, then flush
    test_name = "flush";
    set_ready_mode(READY_HOLD);
    for (int i = 0; i < N_FLUSHED; i++) begin
      send_op({take_bits(32), take_bits(32)}, 1'b0);
    end
    @(negedge clk_i);
    // both stages hold an entry, so the input is blocked
    check_value("flush in_ready_o while full", 64'd0, in_ready_o);
    check_value("flush busy_o while full", 64'd1, busy_o);
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_value("flush busy_o", 64'd0, busy_o);
    check_value("flush out_valid_o", 64'd0, out_valid_o);

    test_name = "after flush";
    set_ready_mode(READY_RANDOM);
    for (int i = 0; i < N_AFTER_FLUSH; i++) begin
      send_op({take_bits(32), take_bits(32)}, 1'b1);
    end
    drop_valid();
    wait_drain();

    @(negedge clk_i);
    if (exp_q.size() != 0 || n_checked + n_flushed != n_pushed) begin
      stop_with_failure($sformatf("%0d operations accepted but %0d checked and %0d flushed",
                                  n_pushed, n_checked, n_flushed));
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// File: complex_mul.sv
module complex_mul (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [4*cplx_fmt_pkg::COMP_W-1:0]    operands_i,
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  input  logic                                 flush_i,
  output cplx_fmt_pkg::cplx_word_u             result_o,
  output logic [cplx_status_pkg::STATUS_W-1:0] status_o,
  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,
  output logic                                 busy_o
);

  import cplx_fmt_pkg::*;
  import cplx_status_pkg::*;

  logic [COMP_W-1:0]   a1, b1, a2, b2;
  logic [COMP_W-1:0]   neg_b1;
  logic                neg_ov;
  cplx_word_u          lhs0, rhs0;
  cplx_word_u          lhs1_d, rhs1_d;
  // stage 1 operands, kept in step with the stage 0 entry
  cplx_word_u          lhs1_q, rhs1_q;
  logic                neg_ov_q;
  cplx_word_u          mul_result;
  logic [STATUS_W-1:0] mul_status;
  logic [STATUS_W-1:0] fma_status_in;
  logic                mul_valid, fma_in_ready;
  logic                mul_busy, fma_busy;

  // packed as {b2, a2, b1, a1}
  assign a1 = operands_i[0*COMP_W +: COMP_W];
  assign b1 = operands_i[1*COMP_W +: COMP_W];
  assign a2 = operands_i[2*COMP_W +: COMP_W];
  assign b2 = operands_i[3*COMP_W +: COMP_W];

  // -(-1) does not fit, clamp it
  assign neg_ov = (b1 == COMP_MIN);
  assign neg_b1 = neg_ov ? COMP_MAX : -b1;

  // stage 0 lanes: a1*a2 and a1*b2
  always_comb begin
    lhs0.parts.re   = a1;
    lhs0.parts.im   = a1;
    rhs0.parts.re   = a2;
    rhs0.parts.im   = b2;
    // stage 1 lanes: -b1*b2 and b1*a2
    lhs1_d.parts.re = neg_b1;
    lhs1_d.parts.im = b1;
    rhs1_d.parts.re = b2;
    rhs1_d.parts.im = a2;
  end

  // load together with stage 0 so the sender may move on
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      lhs1_q   <= lhs1_d;
      rhs1_q   <= rhs1_d;
      neg_ov_q <= neg_ov;
    end
  end

  always_comb begin
    fma_status_in        = mul_status;
    fma_status_in[ST_OV] = mul_status[ST_OV] | neg_ov_q;
  end

  lane_mul_stage mul_add0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .lhs_i       (lhs0),
    .rhs_i       (rhs0),
    .out_valid_o (mul_valid),
    .out_ready_i (fma_in_ready),
    .result_o    (mul_result),
    .status_o    (mul_status),
    .busy_o      (mul_busy)
  );

  lane_fma_stage mul_add1 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .in_valid_i  (mul_valid),
    .in_ready_o  (fma_in_ready),
    .lhs_i       (lhs1_q),
    .rhs_i       (rhs1_q),
    .addend_i    (mul_result),
    .status_i    (fma_status_in),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .busy_o      (fma_busy)
  );

  assign busy_o = mul_busy | fma_busy;

  // pipeline comes out of reset empty
  a_reset_idle: assert property (
    @(posedge clk_i) reset_i |=> !out_valid_o && !busy_o
  );

endmodule

// File: lane_fma_stage.sv
module lane_fma_stage (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 flush_i,
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  input  cplx_fmt_pkg::cplx_word_u             lhs_i,
  input  cplx_fmt_pkg::cplx_word_u             rhs_i,
  input  cplx_fmt_pkg::cplx_word_u             addend_i,
  input  logic [cplx_status_pkg::STATUS_W-1:0] status_i,
  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,
  output cplx_fmt_pkg::cplx_word_u             result_o,
  output logic [cplx_status_pkg::STATUS_W-1:0] status_o,
  output logic                                 busy_o
);

  import cplx_fmt_pkg::*;
  import cplx_status_pkg::*;

  cplx_word_u          sum_word;
  logic [LANES-1:0]    lane_ov;
  logic [LANES-1:0]    lane_nx;
  logic [STATUS_W-1:0] merged_status;

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    logic signed [PROD_W-1:0] prod;
    logic signed [ACC_W-1:0]  addend_ext;
    logic signed [ACC_W-1:0]  sum;

    assign prod = $signed(lhs_i.lane[l]) * $signed(rhs_i.lane[l]);

    // move the addend up to the product's binary point
    assign addend_ext = $signed(addend_i.lane[l]) <<< FRAC_W;

    // exact sum, rounded only once below
    assign sum = prod + addend_ext;

    fixed_round_sat round_i (
      .wide_i (sum),
      .comp_o (sum_word.lane[l]),
      .ov_o   (lane_ov[l]),
      .nx_o   (lane_nx[l])
    );
  end

  // keep whatever the earlier stages flagged
  always_comb begin
    merged_status        = status_i;
    merged_status[ST_OV] = status_i[ST_OV] | (|lane_ov);
    merged_status[ST_NX] = status_i[ST_NX] | (|lane_nx);
  end

  lane_pipe_reg pipe_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .data_i      (sum_word),
    .status_i    (merged_status),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .data_o      (result_o),
    .status_o    (status_o),
    .full_o      (busy_o)
  );

  // flags carried in must still be set on the way out
  a_status_sticky: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (in_valid_i && in_ready_o) |=> ((status_o | $past(status_i)) == status_o)
  );

endmodule

// File: lane_mul_stage.sv
module lane_mul_stage (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 flush_i,
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  input  cplx_fmt_pkg::cplx_word_u             lhs_i,
  input  cplx_fmt_pkg::cplx_word_u             rhs_i,
  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,
  output cplx_fmt_pkg::cplx_word_u             result_o,
  output logic [cplx_status_pkg::STATUS_W-1:0] status_o,
  output logic                                 busy_o
);

  import cplx_fmt_pkg::*;
  import cplx_status_pkg::*;

  cplx_word_u          prod_word;
  logic [LANES-1:0]    lane_ov;
  logic [LANES-1:0]    lane_nx;
  logic [STATUS_W-1:0] lane_status;

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    logic signed [PROD_W-1:0] prod;
    logic signed [ACC_W-1:0]  prod_ext;

    // exact product, 30 fraction bits
    assign prod     = $signed(lhs_i.lane[l]) * $signed(rhs_i.lane[l]);
    assign prod_ext = prod;

    // -1 * -1 lands above COMP_MAX and saturates here
    fixed_round_sat round_i (
      .wide_i (prod_ext),
      .comp_o (prod_word.lane[l]),
      .ov_o   (lane_ov[l]),
      .nx_o   (lane_nx[l])
    );
  end

  always_comb begin
    lane_status        = '0;
    lane_status[ST_OV] = |lane_ov;
    lane_status[ST_NX] = |lane_nx;
  end

  lane_pipe_reg pipe_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .data_i      (prod_word),
    .status_i    (lane_status),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .data_o      (result_o),
    .status_o    (status_o),
    .full_o      (busy_o)
  );

endmodule

// File: lane_pipe_reg.sv
module lane_pipe_reg (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               flush_i,
  input  logic                               in_valid_i,
  output logic                               in_ready_o,
  input  logic [31:0]                        data_i,
  input  logic [cplx_status_pkg::STATUS_W-1:0] status_i,
  output logic                               out_valid_o,
  input  logic                               out_ready_i,
  output logic [31:0]                        data_o,
  output logic [cplx_status_pkg::STATUS_W-1:0] status_o,
  output logic                               full_o
);

  import cplx_status_pkg::*;

  logic                valid_q;
  logic [31:0]         data_q;
  logic [STATUS_W-1:0] status_q;

  // accept when empty or when the entry leaves this cycle
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // payload only moves on a transfer in
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q   <= data_i;
      status_q <= status_i;
    end
  end

  assign out_valid_o = valid_q;
  assign full_o      = valid_q;
  assign data_o      = data_q;
  assign status_o    = status_q;

  // stalled output must hold still
  a_stall_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (out_valid_o && !out_ready_i) |=> $stable(data_o) && $stable(status_o)
  );

  // nothing survives a flush
  a_flush_clears: assert property (
    @(posedge clk_i) disable iff (reset_i)
    flush_i |=> !out_valid_o
  );

endmodule

// File: fixed_round_sat.sv
module fixed_round_sat (
  input  logic signed [cplx_fmt_pkg::ACC_W-1:0]  wide_i,
  output logic        [cplx_fmt_pkg::COMP_W-1:0] comp_o,
  output logic                                   ov_o,
  output logic                                   nx_o
);

  import cplx_fmt_pkg::*;

  // integer part after dropping the extra fraction bits
  logic signed [ACC_W-FRAC_W-1:0] kept;
  logic                           guard;
  logic                           sticky;
  logic                           round_up;
  // one extra bit so the increment cannot wrap
  logic signed [ACC_W-FRAC_W:0]   rounded;

  assign kept   = wide_i[ACC_W-1:FRAC_W];
  assign guard  = wide_i[FRAC_W-1];
  assign sticky = |wide_i[FRAC_W-2:0];

  // round to nearest, ties go to the even neighbour
  assign round_up = guard & (sticky | kept[0]);

  assign rounded = kept + $signed({1'b0, round_up});

  // any dropped one makes the result inexact
  assign nx_o = |wide_i[FRAC_W-1:0];

  // clamp into the Q1.15 range
  always_comb begin
    ov_o   = 1'b0;
    comp_o = rounded[COMP_W-1:0];
    if (rounded > COMP_MAX) begin
      comp_o = COMP_MAX;
      ov_o   = 1'b1;
    end else if (rounded < COMP_MIN) begin
      comp_o = COMP_MIN;
      ov_o   = 1'b1;
    end
  end

endmodule

// File: cplx_status_pkg.sv
package cplx_status_pkg;

  // sticky status word that travels with each result
  localparam int STATUS_W = 2;

  // saturation happened somewhere along the way
  localparam int ST_OV = 0;

  // rounding threw away nonzero bits
  localparam int ST_NX = 1;

endpackage

// File: cplx_fmt_pkg.sv
package cplx_fmt_pkg;

  // one real component in Q1.15
  localparam int COMP_W = 16;
  localparam int FRAC_W = 15;

  // exact product of two components
  localparam int PROD_W = 2 * COMP_W;

  // product plus aligned addend, two guard bits on top
  localparam int ACC_W = PROD_W + 2;

  // vector lanes per complex word
  localparam int LANES = 2;

  // saturation limits, nearly +1 and exactly -1
  localparam logic signed [COMP_W-1:0] COMP_MAX = {1'b0, {(COMP_W-1){1'b1}}};
  localparam logic signed [COMP_W-1:0] COMP_MIN = {1'b1, {(COMP_W-1){1'b0}}};

  // complex word, seen as re/im pair or as two vector lanes
  // lane 0 overlays re, lane 1 overlays im
  typedef union packed {
    struct packed {
      logic [COMP_W-1:0] im;
      logic [COMP_W-1:0] re;
    } parts;
    logic [LANES-1:0][COMP_W-1:0] lane;
  } cplx_word_u;

endpackage
